/* hw/pio.sv */
`timescale 1ns/1ns
module pio (
  input  logic             clk,
  input  logic             reset,
  input  pio_pkg::mindex_t mindex,
  input  pio_pkg::word_t   din,
  input  pio_pkg::addr_t   index,
  input  pio_pkg::action_e action,
  output pio_pkg::word_t   dout,
  input  pio_pkg::word_t   gpio_in,
  output pio_pkg::word_t   gpio_out,
  output pio_pkg::word_t   gpio_dir,
  output logic             irq0,
  output logic             irq1
);
  import pio_pkg::*;

  instr_t imem [imem_depth];
  instr_t imm_instr;
  logic [num_machines-1:0] imm_valid;
  logic [num_machines-1:0] en;

  addr_t  wrap_start [num_machines];
  addr_t  wrap_end   [num_machines];
  addr_t  jmp_pin    [num_machines];
  addr_t  in_base    [num_machines];
  addr_t  out_base   [num_machines];
  addr_t  set_base   [num_machines];
  count_t in_count   [num_machines];
  count_t out_count  [num_machines];
  count_t set_count  [num_machines];

  addr_t  pc           [num_machines];
  word_t  pin_val      [num_machines];
  word_t  pin_dir      [num_machines];
  word_t  pin_val_mask [num_machines];
  word_t  pin_dir_mask [num_machines];
  word_t  tx_head      [num_machines];
  word_t  rx_data      [num_machines];
  word_t  rx_head      [num_machines];

  logic [num_machines-1:0] tx_push;
  logic [num_machines-1:0] tx_pop;
  logic [num_machines-1:0] tx_empty;
  logic [num_machines-1:0] tx_full;
  logic [num_machines-1:0] rx_push;
  logic [num_machines-1:0] rx_pop;
  logic [num_machines-1:0] rx_empty;
  logic [num_machines-1:0] rx_full;

  always_comb begin
    for (int j = 0; j < num_machines; j++) begin
      tx_push[j] = (action == act_push) && (mindex == mindex_t'(j)) && !tx_full[j];
      rx_pop[j]  = (action == act_pull) && (mindex == mindex_t'(j));
    end
  end

  always_ff @(posedge clk) begin
    if (action == act_instr) imem[index] <= din[15:0];
    if (action == act_imm) imm_instr <= din[15:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      en        <= '0;
      imm_valid <= '0;
      dout      <= '0;
      for (int j = 0; j < num_machines; j++) begin
        wrap_start[j] <= '0;
        wrap_end[j]   <= '0;
        jmp_pin[j]    <= '0;
        in_base[j]    <= '0;
        out_base[j]   <= '0;
        set_base[j]   <= '0;
        in_count[j]   <= '0;
        out_count[j]  <= '0;
        set_count[j]  <= '0;
      end
    end else begin
      imm_valid <= '0;
      case (action)
        act_wrap: begin
          wrap_end[mindex]   <= index;
          wrap_start[mindex] <= din[4:0];
        end
        act_pull: if (!rx_empty[mindex]) dout <= rx_head[mindex];
        act_pins: begin // Side-set field din[31:24] unused
          set_count[mindex] <= din[2:0];
          set_base[mindex]  <= din[7:3];
          out_count[mindex] <= din[10:8];
          out_base[mindex]  <= din[15:11];
          in_count[mindex]  <= din[18:16];
          in_base[mindex]   <= din[23:19];
        end
        act_enable:  en <= din[num_machines-1:0];
        act_imm:     imm_valid[mindex] <= 1'b1;
        act_jmp_pin: jmp_pin[mindex] <= din[4:0];
        default: ;
      endcase
    end
  end

  for (genvar j = 0; j < num_machines; j++) begin : g_mach
    pio_machine i_machine (
      .clk(clk), .reset(reset), .en(en[j]),
      .instr(imm_valid[j] ? imm_instr : imem[pc[j]]), .imm(imm_valid[j]),
      .wrap_start(wrap_start[j]), .wrap_end(wrap_end[j]), .jmp_pin(jmp_pin[j]),
      .gpio_in(gpio_in),
      .in_base(in_base[j]), .out_base(out_base[j]), .set_base(set_base[j]),
      .in_count(in_count[j]), .out_count(out_count[j]), .set_count(set_count[j]),
      .tx_data(tx_head[j]), .tx_empty(tx_empty[j]), .rx_full(rx_full[j]),
      .pc(pc[j]), .pin_val(pin_val[j]), .pin_dir(pin_dir[j]),
      .pin_val_mask(pin_val_mask[j]), .pin_dir_mask(pin_dir_mask[j]),
      .tx_pop(tx_pop[j]), .rx_push(rx_push[j]), .rx_data(rx_data[j])
    );

    pio_fifo i_tx_fifo (
      .clk(clk), .reset(reset), .push(tx_push[j]), .pop(tx_pop[j]),
      .din(din), .dout(tx_head[j]), .empty(tx_empty[j]), .full(tx_full[j])
    );

    pio_fifo i_rx_fifo (
      .clk(clk), .reset(reset), .push(rx_push[j]), .pop(rx_pop[j]),
      .din(rx_data[j]), .dout(rx_head[j]), .empty(rx_empty[j]), .full(rx_full[j])
    );
  end

  pio_pin_merge i_pin_merge (
    .pin_val(pin_val), .pin_dir(pin_dir),
    .pin_val_mask(pin_val_mask), .pin_dir_mask(pin_dir_mask),
    .gpio_out(gpio_out), .gpio_dir(gpio_dir)
  );

  assign irq0 = |(en & ~rx_empty); // Receive data waiting
  assign irq1 = |(en & tx_empty);  // Transmit FIFO needs data

endmodule

/* hw/pio_fifo.sv */
`timescale 1ns/1ns
module pio_fifo (
  input  logic          clk,
  input  logic          reset,
  input  logic          push,
  input  logic          pop,
  input  pio_pkg::word_t din,
  output pio_pkg::word_t dout,
  output logic          empty,
  output logic          full
);
  import pio_pkg::*;

  word_t                 mem [fifo_depth];
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  do_push;
  logic                  do_pop;

  assign empty   = (count == '0);
  assign full    = (count == fifo_depth[fifo_ptr_w:0]);
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;
  assign dout    = mem[rd_ptr]; // Head always visible

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* hw/pio_machine.sv */
`timescale 1ns/1ns
module pio_machine (
  input  logic           clk,
  input  logic           reset,
  input  logic           en,
  input  pio_pkg::instr_t instr,
  input  logic           imm,
  input  pio_pkg::addr_t  wrap_start,
  input  pio_pkg::addr_t  wrap_end,
  input  pio_pkg::addr_t  jmp_pin,
  input  pio_pkg::word_t  gpio_in,
  input  pio_pkg::addr_t  in_base,
  input  pio_pkg::addr_t  out_base,
  input  pio_pkg::addr_t  set_base,
  input  pio_pkg::count_t in_count,
  input  pio_pkg::count_t out_count,
  input  pio_pkg::count_t set_count,
  input  pio_pkg::word_t  tx_data,
  input  logic           tx_empty,
  input  logic           rx_full,
  output pio_pkg::addr_t  pc,
  output pio_pkg::word_t  pin_val,
  output pio_pkg::word_t  pin_dir,
  output pio_pkg::word_t  pin_val_mask,
  output pio_pkg::word_t  pin_dir_mask,
  output logic           tx_pop,
  output logic           rx_push,
  output pio_pkg::word_t  rx_data
);
  import pio_pkg::*;

  function automatic word_t rotl(input word_t w, input addr_t b);
    logic [5:0] rb;
    rb = 6'd32 - {1'b0, b};
    return (w << b) | (w >> rb); // b of 0 gives w
  endfunction

  function automatic word_t rotr(input word_t w, input addr_t b);
    logic [5:0] lb;
    lb = 6'd32 - {1'b0, b};
    return (w >> b) | (w << lb);
  endfunction

  function automatic word_t count_mask(input count_t c);
    word_t m;
    if (c == '0) begin
      m = word_t'(8'hff);
    end else begin
      m = (word_t'(1) << c) - word_t'(1);
    end
    return m;
  endfunction

  opcode_e    op;
  src_dst_e   sd;
  jmp_cond_e  cond;
  shift_t     shift_n;
  logic [5:0] n_bits;
  word_t      n_mask;
  word_t      x;
  word_t      y;
  word_t      isr;
  word_t      osr;
  word_t      in_window;
  word_t      in_src;
  word_t      out_data;
  word_t      set_data;
  word_t      out_win_mask;
  word_t      out_win_val;
  word_t      set_win_mask;
  word_t      set_win_val;
  logic       exec;
  logic       is_pull;
  logic       is_push;
  logic       stall;
  logic       jump_taken;

  assign exec    = en | imm; // Immediates run even when disabled
  assign op      = opcode_e'(instr[15:13]);
  assign sd      = src_dst_e'(instr[7:5]);
  assign cond    = jmp_cond_e'(instr[7:5]);
  assign shift_n = instr[4:0];
  assign n_bits  = (shift_n == '0) ? 6'd32 : {1'b0, shift_n};
  assign n_mask  = (word_t'(1) << n_bits) - word_t'(1);

  assign is_pull = (op == op_pushpull) & instr[7];
  assign is_push = (op == op_pushpull) & ~instr[7];
  assign stall   = (is_pull & tx_empty) | (is_push & rx_full);
  assign tx_pop  = exec & is_pull & ~tx_empty;
  assign rx_push = exec & is_push & ~rx_full;
  assign rx_data = isr;

  assign in_window = rotr(gpio_in, in_base) & count_mask(in_count);
  assign out_data  = osr & n_mask;
  assign set_data  = word_t'(instr[4:0]);

  assign out_win_mask = rotl(count_mask(out_count), out_base);
  assign out_win_val  = rotl(out_data, out_base);
  assign set_win_mask = rotl(count_mask(set_count), set_base);
  assign set_win_val  = rotl(set_data, set_base);

  always_comb begin
    case (sd)
      sd_pins: in_src = in_window;
      sd_x:    in_src = x;
      sd_y:    in_src = y;
      default: in_src = '0;
    endcase
  end

  always_comb begin
    jump_taken = 1'b0;
    if (op == op_jmp) begin
      case (cond)
        cond_always: jump_taken = 1'b1;
        cond_not_x:  jump_taken = (x == '0);
        cond_x_dec:  jump_taken = (x != '0); // Tested before decrement
        cond_not_y:  jump_taken = (y == '0);
        cond_y_dec:  jump_taken = (y != '0);
        cond_x_ne_y: jump_taken = (x != y);
        cond_pin:    jump_taken = gpio_in[jmp_pin];
        default:     jump_taken = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc           <= wrap_start;
      x            <= '0;
      y            <= '0;
      isr          <= '0;
      osr          <= '0;
      pin_val      <= '0;
      pin_dir      <= '0;
      pin_val_mask <= '0;
      pin_dir_mask <= '0;
    end else if (exec && !stall) begin
      case (op)
        op_jmp: begin
          if (cond == cond_x_dec) x <= x - 1'b1;
          if (cond == cond_y_dec) y <= y - 1'b1;
        end
        op_in: isr <= (isr << n_bits) | (in_src & n_mask);
        op_out: begin
          osr <= osr >> n_bits;
          case (sd)
            sd_pins: begin
              pin_val      <= (pin_val & ~out_win_mask) | (out_win_val & out_win_mask);
              pin_val_mask <= out_win_mask;
            end
            sd_pindirs: begin
              pin_dir      <= (pin_dir & ~out_win_mask) | (out_win_val & out_win_mask);
              pin_dir_mask <= out_win_mask;
            end
            sd_x:    x <= out_data;
            sd_y:    y <= out_data;
            default: ;
          endcase
        end
        op_pushpull: begin
          if (is_pull) osr <= tx_data;
          else isr <= '0; // ISR clears once pushed
        end
        op_set: begin
          case (sd)
            sd_pins: begin
              pin_val      <= (pin_val & ~set_win_mask) | (set_win_val & set_win_mask);
              pin_val_mask <= set_win_mask;
            end
            sd_pindirs: begin
              pin_dir      <= (pin_dir & ~set_win_mask) | (set_win_val & set_win_mask);
              pin_dir_mask <= set_win_mask;
            end
            sd_x:    x <= set_data;
            sd_y:    y <= set_data;
            default: ;
          endcase
        end
        default: ;
      endcase
      if (jump_taken) begin
        pc <= instr[4:0];
      end else if (imm) begin
        pc <= pc;
      end else if (pc == wrap_end) begin
        pc <= wrap_start;
      end else begin
        pc <= pc + 1'b1;
      end
    end else if (!exec) begin
      pc <= wrap_start; // Idle machine waits at its start address
    end
  end

endmodule

/* hw/pio_pin_merge.sv */
`timescale 1ns/1ns
module pio_pin_merge (
  input  pio_pkg::word_t pin_val      [pio_pkg::num_machines],
  input  pio_pkg::word_t pin_dir      [pio_pkg::num_machines],
  input  pio_pkg::word_t pin_val_mask [pio_pkg::num_machines],
  input  pio_pkg::word_t pin_dir_mask [pio_pkg::num_machines],
  output pio_pkg::word_t gpio_out,
  output pio_pkg::word_t gpio_dir
);
  import pio_pkg::*;

  word_t out_acc;
  word_t dir_acc;

  // Later machines overwrite earlier ones, so the highest index wins
  always_comb begin
    out_acc = '0;
    dir_acc = '0;
    for (int m = 0; m < num_machines; m++) begin
      out_acc = (out_acc & ~pin_val_mask[m]) | (pin_val[m] & pin_val_mask[m]);
      dir_acc = (dir_acc & ~pin_dir_mask[m]) | (pin_dir[m] & pin_dir_mask[m]);
    end
  end

  assign gpio_out = out_acc;
  assign gpio_dir = dir_acc;

endmodule

/* hw/pio_pkg.sv */
package pio_pkg;

  localparam int num_machines = 4;
  localparam int imem_depth   = 32;
  localparam int fifo_depth   = 4;
  localparam int fifo_ptr_w   = $clog2(fifo_depth);

  typedef logic [31:0] word_t;
  typedef logic [15:0] instr_t;
  typedef logic [4:0]  addr_t;   // Also pin base and pin index
  typedef logic [1:0]  mindex_t;
  typedef logic [2:0]  count_t;  // 0 means 8 pins
  typedef logic [4:0]  shift_t;  // 0 means 32 bits

  // Instruction bits 15:13
  typedef enum logic [2:0] {
    op_jmp      = 3'd0,
    op_in       = 3'd2,
    op_out      = 3'd3,
    op_pushpull = 3'd4,
    op_set      = 3'd7
  } opcode_e;

  // JMP condition in bits 7:5
  typedef enum logic [2:0] {
    cond_always = 3'd0,
    cond_not_x  = 3'd1,
    cond_x_dec  = 3'd2,
    cond_not_y  = 3'd3,
    cond_y_dec  = 3'd4,
    cond_x_ne_y = 3'd5,
    cond_pin    = 3'd6
  } jmp_cond_e;

  // IN source or OUT and SET destination in bits 7:5
  typedef enum logic [2:0] {
    sd_pins    = 3'd0,
    sd_x       = 3'd1,
    sd_y       = 3'd2,
    sd_null    = 3'd3,
    sd_pindirs = 3'd4
  } src_dst_e;

  typedef enum logic [3:0] {
    act_none    = 4'd0,
    act_instr   = 4'd1,
    act_wrap    = 4'd2,
    act_pull    = 4'd3,
    act_push    = 4'd4,
    act_pins    = 4'd5,
    act_enable  = 4'd6,
    act_imm     = 4'd9,
    act_jmp_pin = 4'd10
  } action_e;

endpackage

/* pio.f */
hw/pio_pkg.sv
hw/pio_fifo.sv
hw/pio_machine.sv
hw/pio_pin_merge.sv
hw/pio.sv
tb/pio_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module pio_tb -f pio.f -o pio_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pio_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

/* tb/pio_tb.sv */
`timescale 1ns/1ns
module pio_tb;
  import pio_pkg::*;

  localparam int wait_limit = 200;

  logic    clk;
  logic    reset;
  mindex_t mindex;
  word_t   din;
  addr_t   index;
  action_e action;
  word_t   dout;
  word_t   gpio_in;
  word_t   gpio_out;
  word_t   gpio_dir;
  logic    irq0;
  logic    irq1;

  integer seed;
  int     checks;
  int     errors;

  pio i_pio (
    .clk(clk), .reset(reset), .mindex(mindex), .din(din), .index(index),
    .action(action), .dout(dout), .gpio_in(gpio_in), .gpio_out(gpio_out),
    .gpio_dir(gpio_dir), .irq0(irq0), .irq1(irq1)
  );

  always #2 clk = ~clk;

  // Low cnt bits of data placed from base upward with wrap at 32
  function automatic word_t exp_out_pins(input word_t data, input addr_t base,
                                         input count_t cnt);
    word_t r;
    int    n;
    addr_t k;
    addr_t p;
    n = (cnt == 3'd0) ? 8 : int'(cnt);
    r = '0;
    for (int i = 0; i < n; i++) begin
      k = addr_t'(i);
      p = base + k;
      r[p] = data[k];
    end
    return r;
  endfunction

  function automatic word_t exp_in_pins(input word_t pins, input addr_t base,
                                        input count_t cnt);
    word_t r;
    int    n;
    addr_t k;
    addr_t p;
    n = (cnt == 3'd0) ? 8 : int'(cnt);
    r = '0;
    for (int i = 0; i < n; i++) begin
      k = addr_t'(i);
      p = base + k;
      r[k] = pins[p];
    end
    return r;
  endfunction

  function automatic word_t exp_countdown(input int start, input int k);
    return word_t'(start - k);
  endfunction

  function automatic word_t pins_cfg(input addr_t ib, input count_t ic, input addr_t ob,
                                     input count_t oc, input addr_t sb, input count_t sc);
    return {8'h00, ib, ic, ob, oc, sb, sc};
  endfunction

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic host_cmd(input action_e act, input mindex_t m, input addr_t idx,
                          input word_t data);
    @(posedge clk);
    action <= act;
    mindex <= m;
    index  <= idx;
    din    <= data;
    @(posedge clk);
    action <= act_none; // Strobe lasts one cycle
  endtask

  task automatic write_instr(input addr_t a, input instr_t w);
    host_cmd(act_instr, '0, a, word_t'(w));
  endtask

  task automatic read_rx(input mindex_t m, output word_t data);
    int n;
    n = 0;
    @(negedge clk);
    while (irq0 !== 1'b1 && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (irq0 !== 1'b1) begin
      errors++;
      $display("Timed out waiting for irq0 before reading machine %0d", m);
      data = '0;
    end else begin
      host_cmd(act_pull, m, '0, '0);
      @(negedge clk);
      data = dout;
    end
  endtask

  task automatic wait_gpio(input word_t exp_out);
    int n;
    n = 0;
    @(negedge clk);
    while (gpio_out !== exp_out && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (gpio_out !== exp_out) begin
      $display("Timed out waiting for gpio_out to reach %h", exp_out);
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    $display("%s: finished with %0d errors", name, errors - start_errors);
  endtask

  task automatic check_reset_state();
    int e0;
    e0 = errors;
    apply_reset();
    @(negedge clk);
    check_word(gpio_dir, '0, "gpio_dir after reset");
    check_word(gpio_out, '0, "gpio_out after reset");
    check_word(dout, '0, "dout after reset");
    check_bit(irq0, 1'b0, "irq0 after reset");
    check_bit(irq1, 1'b0, "irq1 after reset");
    for (int a = 0; a < imem_depth; a++) begin
      write_instr(addr_t'(a), instr_t'(a)); // JMP to own address
    end
    host_cmd(act_enable, '0, '0, 32'h1);
    @(negedge clk);
    check_bit(irq1, 1'b1, "irq1 with empty tx FIFO");
    report_test("reset state", e0);
  endtask

  task automatic run_echo();
    int    e0;
    word_t words [4];
    word_t got;
    e0 = errors;
    apply_reset();
    write_instr(5'd0, 16'h8080); // PULL
    write_instr(5'd1, 16'h6020); // OUT x,32
    write_instr(5'd2, 16'h4020); // IN x,32
    write_instr(5'd3, 16'h8000); // PUSH
    host_cmd(act_wrap, 2'd0, 5'd3, 32'd0);
    host_cmd(act_enable, '0, '0, 32'h1);
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < 4; i++) begin
        words[i] = $random(seed);
        host_cmd(act_push, 2'd0, '0, words[i]);
      end
      for (int i = 0; i < 4; i++) begin
        read_rx(2'd0, got);
        check_word(got, words[i], "echo word");
      end
    end
    check_bit(irq0, 1'b0, "irq0 after echo drained");
    report_test("echo", e0);
  endtask

  task automatic out_pins_walk();
    int     e0;
    addr_t  base;
    count_t cnt;
    word_t  w;
    e0 = errors;
    apply_reset();
    base = addr_t'($random(seed));
    cnt  = count_t'(1 + {$random(seed)} % 5); // SET data covers 5 pins
    host_cmd(act_pins, 2'd0, '0, pins_cfg('0, '0, base, cnt, base, cnt));
    write_instr(5'd0, 16'h8080); // PULL
    write_instr(5'd1, 16'h6000); // OUT pins,32
    host_cmd(act_wrap, 2'd0, 5'd1, 32'd0);
    host_cmd(act_imm, 2'd0, '0, 32'h0000_E09F); // SET pindirs,31
    host_cmd(act_enable, '0, '0, 32'h1);
    for (int i = 0; i < 6; i++) begin
      w = $random(seed);
      host_cmd(act_push, 2'd0, '0, w);
      wait_gpio(exp_out_pins(w, base, cnt));
      check_word(gpio_out, exp_out_pins(w, base, cnt), "gpio_out after OUT pins");
      check_word(gpio_dir, exp_out_pins('1, base, cnt), "gpio_dir after SET pindirs");
    end
    report_test("out pins", e0);
  endtask

  task automatic in_pins_sample();
    int     e0;
    addr_t  base;
    count_t cnt;
    word_t  got;
    e0 = errors;
    apply_reset();
    base = addr_t'($random(seed));
    cnt  = count_t'($random(seed));
    @(posedge clk);
    gpio_in <= $random(seed);
    host_cmd(act_pins, 2'd0, '0, pins_cfg(base, cnt, '0, '0, '0, '0));
    write_instr(5'd0, 16'h4000); // IN pins,32
    write_instr(5'd1, 16'h8000); // PUSH
    host_cmd(act_wrap, 2'd0, 5'd1, 32'd0);
    host_cmd(act_enable, '0, '0, 32'h1);
    for (int i = 0; i < 6; i++) begin
      read_rx(2'd0, got);
      check_word(got, exp_in_pins(gpio_in, base, cnt), "IN pins word");
    end
    report_test("in pins", e0);
  endtask

  task automatic countdown_loop();
    int    e0;
    int    k;
    addr_t pin;
    word_t g;
    word_t got;
    e0 = errors;
    apply_reset();
    write_instr(5'd0, 16'h4025); // IN x,5
    write_instr(5'd1, 16'h8000); // PUSH
    write_instr(5'd2, 16'h0040); // JMP x--,0
    write_instr(5'd3, 16'h0003); // Park here
    host_cmd(act_wrap, 2'd1, 5'd3, 32'd0);
    k = 1 + int'({$random(seed)} % 6);
    host_cmd(act_imm, 2'd1, '0, word_t'(32'hE020 + k)); // SET x,k
    host_cmd(act_enable, '0, '0, 32'h2);
    for (int i = 0; i <= k; i++) begin
      read_rx(2'd1, got);
      check_word(got, exp_countdown(k, i), "countdown word");
    end
    check_bit(irq0, 1'b0, "irq0 after countdown");
    for (int lvl = 0; lvl < 2; lvl++) begin
      apply_reset();
      write_instr(5'd0, 16'h00C3); // JMP pin,3
      write_instr(5'd1, 16'hE02A); // SET x,10
      write_instr(5'd2, 16'h0004);
      write_instr(5'd3, 16'hE035); // SET x,21
      write_instr(5'd4, 16'h4025);
      write_instr(5'd5, 16'h8000);
      write_instr(5'd6, 16'h0006);
      host_cmd(act_wrap, 2'd1, 5'd6, 32'd0);
      pin = addr_t'($random(seed));
      host_cmd(act_jmp_pin, 2'd1, '0, word_t'(pin));
      g      = $random(seed);
      g[pin] = (lvl == 1);
      @(posedge clk);
      gpio_in <= g;
      host_cmd(act_enable, '0, '0, 32'h2);
      read_rx(2'd1, got);
      check_word(got, (lvl == 1) ? 32'd21 : 32'd10, "JMP pin result");
    end
    report_test("countdown and jmp pin", e0);
  endtask

  task automatic pin_priority();
    int    e0;
    addr_t b0;
    addr_t b2;
    word_t d0;
    word_t d2;
    word_t exp;
    e0 = errors;
    apply_reset();
    b0 = addr_t'($random(seed));
    b2 = b0 + 5'd2; // Three pins overlap
    d0 = word_t'({$random(seed)} % 32);
    d2 = d0 ^ 32'h1F;
    host_cmd(act_pins, 2'd0, '0, pins_cfg('0, '0, '0, '0, b0, 3'd5));
    host_cmd(act_pins, 2'd2, '0, pins_cfg('0, '0, '0, '0, b2, 3'd5));
    host_cmd(act_imm, 2'd0, '0, 32'hE000 | d0); // SET pins
    host_cmd(act_imm, 2'd2, '0, 32'hE000 | d2);
    exp = (exp_out_pins(d0, b0, 3'd5) & ~exp_out_pins('1, b2, 3'd5)) |
          exp_out_pins(d2, b2, 3'd5);
    wait_gpio(exp);
    check_word(gpio_out, exp, "gpio_out with overlapping SET pins");
    check_word(gpio_dir, '0, "gpio_dir with no pindirs written");
    report_test("priority", e0);
  endtask

  initial begin
    clk     = 1'b0;
    reset   = 1'b1;
    action  = act_none;
    mindex  = '0;
    din     = '0;
    index   = '0;
    gpio_in = '0;
    seed    = 38;
    checks  = 0;
    errors  = 0;
    check_reset_state();
    run_echo();
    out_pins_walk();
    in_pins_sample();
    countdown_loop();
    pin_priority();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
